/* bender.yml */
package:
  name: exec_unit

sources:
  - design/exec_pkg.sv
  - design/issue_port.sv
  - design/alu_core.sv
  - design/md_divider.sv
  - design/result_fifo.sv
  - design/result_port.sv
  - design/exec_top.sv
  - target: test
    files:
      - testbench/exec_properties.sv
      - testbench/exec_tb.sv

/* exec_top.f */
design/exec_pkg.sv
design/issue_port.sv
design/alu_core.sv
design/md_divider.sv
design/result_fifo.sv
design/result_port.sv
design/exec_top.sv
testbench/exec_properties.sv
testbench/exec_tb.sv

/* testbench/exec_tests.txt */
# op  src1  src2  result  overflow  trap   (all values hex, one operation per line)
# HI/LO-only ops return result 0, mfhi/mflo read what the lines before them left
ADD   7fffffff 00000001 80000000 1 0
ADD   00000005 fffffffd 00000002 0 0
SUB   80000000 00000001 7fffffff 1 0
ADDU  7fffffff 00000001 80000000 0 0
SUBU  00000003 00000005 fffffffe 0 0
SLT   ffffffff 00000001 00000001 0 0
SLTU  ffffffff 00000001 00000000 0 0
AND   f0f0ff00 0ff0f0f0 00f0f000 0 0
OR    f0f0ff00 0ff0f0f0 fff0fff0 0 0
NOR   12345678 0000ffff edcb0000 0 0
XOR   aaaa5555 ffff0000 55555555 0 0
LUI   00000000 0000abcd abcd0000 0 0
SLL   00000004 0000000f 000000f0 0 0
SRL   00000008 80000000 00800000 0 0
SRA   00000004 80000000 f8000000 0 0
CLO   ffffffff 00000000 00000020 0 0
CLO   f0000000 00000000 00000004 0 0
CLZ   00000000 00000000 00000020 0 0
CLZ   00010000 00000000 0000000f 0 0
MOVN  ffffffff 12345678 12345678 0 0
MOVN  00000000 deadbeef 00000000 0 0
MOVZ  00000000 cafef00d cafef00d 0 0
TEQ   00000005 00000005 00000000 0 1
TNE   00000005 00000005 00000000 0 0
TGE   ffffffff 00000001 00000000 0 0
TGE   00000003 00000003 00000000 0 1
TGEU  ffffffff 00000001 00000000 0 1
TLT   ffffffff 00000001 00000000 0 1
TLTU  00000002 00000003 00000000 0 1
TLTU  00000003 00000003 00000000 0 0
MULT  fffffffe 00000003 00000000 0 0
MFHI  00000000 00000000 ffffffff 0 0
MFLO  00000000 00000000 fffffffa 0 0
MULTU ffffffff 00000002 00000000 0 0
MFHI  00000000 00000000 00000001 0 0
MTHI  00000000 00000000 00000000 0 0
MTLO  00000010 00000000 00000000 0 0
MADD  00000003 00000004 00000000 0 0
MFLO  00000000 00000000 0000001c 0 0
MSUB  00000002 00000010 00000000 0 0
MFHI  00000000 00000000 ffffffff 0 0
MFLO  00000000 00000000 fffffffc 0 0
MADDU ffffffff ffffffff 00000000 0 0
MFHI  00000000 00000000 fffffffd 0 0
MTHI  12345678 00000000 00000000 0 0
MTLO  9abcdef0 00000000 00000000 0 0
MFHI  00000000 00000000 12345678 0 0
MFLO  00000000 00000000 9abcdef0 0 0
DIV   fffffff9 00000002 00000000 0 0
MFHI  00000000 00000000 ffffffff 0 0
MFLO  00000000 00000000 fffffffd 0 0
DIVU  00000064 00000007 00000000 0 0
MFHI  00000000 00000000 00000002 0 0
MFLO  00000000 00000000 0000000e 0 0
DIVU  12345678 00000000 00000000 0 0
MFHI  00000000 00000000 12345678 0 0
MFLO  00000000 00000000 ffffffff 0 0
DIV   fffffff0 00000000 00000000 0 0
MFHI  00000000 00000000 fffffff0 0 0
MFLO  00000000 00000000 ffffffff 0 0

/* testbench/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

    localparam time PERIOD          = 100;
    localparam time DRIVE_DELAY     = 1;
    localparam int  CYCLES_PER_TEST = 60;

    logic                 clk;
    logic                 reset;
    logic                 in_req;
    exec_pkg::exec_req_t  in_data;
    logic                 in_ack;
    logic                 out_req;
    logic                 out_ack;
    exec_pkg::exec_resp_t out_data;

    exec_pkg::exec_req_t  reqs[$];
    exec_pkg::exec_resp_t expected[$];
    logic [7:0]           lfsr = 8'd8;
    bit                   loaded = 1'b0;

    exec_top #(.FIFO_DEPTH(4)) i_dut (
        .clk(clk), .reset(reset), .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .out_req(out_req), .out_ack(out_ack), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s expected %h, got %h",
                               $time, name, exp, got));
        end
    endtask

    function automatic bit op_from_name(input string name, output exec_pkg::exec_op_e op);
        op = op.first();
        for (int i = 0; i < op.num(); i++) begin
            if (op.name() == name) return 1'b1;
            op = op.next();
        end
        return 1'b0;
    endfunction

    task automatic load_tests();
        int                   fd;
        int                   n;
        string                tok;
        string                rest;
        exec_pkg::exec_op_e   op;
        exec_pkg::exec_req_t  req_item;
        exec_pkg::exec_resp_t resp_item;
        logic [31:0]          src1;
        logic [31:0]          src2;
        logic [31:0]          res;
        logic [31:0]          ovf;
        logic [31:0]          trp;
        fd = $fopen("testbench/exec_tests.txt", "r");
        if (fd == 0) begin
            fail_run("could not open testbench/exec_tests.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);  // skip comment line
                end else if (!op_from_name(tok, op)) begin
                    fail_run({"unknown operation in test file: ", tok});
                end else begin
                    n = $fscanf(fd, "%h %h %h %h %h", src1, src2, res, ovf, trp);
                    if (n != 5) begin
                        fail_run({"incomplete test line for operation ", tok});
                    end else begin
                        req_item.op        = op;
                        req_item.src1      = src1;
                        req_item.src2      = src2;
                        resp_item.result   = res;
                        resp_item.overflow = ovf[0];
                        resp_item.trap     = trp[0];
                        reqs.push_back(req_item);
                        expected.push_back(resp_item);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic pick_ack_delay(output int cycles);
        cycles = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr   = lfsr_step(lfsr);
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_producer();
        foreach (reqs[i]) begin
            next_cycle();
            in_data = reqs[i];
            in_req  = 1'b1;
            while (!in_ack) next_cycle();
            in_req = 1'b0;
            while (in_ack) next_cycle();
        end
    endtask

    task automatic run_consumer();
        int delay;
        foreach (expected[i]) begin
            while (!out_req) next_cycle();
            pick_ack_delay(delay);
            repeat (delay) next_cycle();  // back-pressure
            check_value("out_data.result", out_data.result, expected[i].result);
            check_value("out_data.overflow", 32'(out_data.overflow),
                        32'(expected[i].overflow));
            check_value("out_data.trap", 32'(out_data.trap), 32'(expected[i].trap));
            out_ack = 1'b1;
            next_cycle();
            while (out_req) next_cycle();
            out_ack = 1'b0;
        end
    endtask

    initial begin
        reset   = 1'b1;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        fork
            run_producer();
            run_consumer();
        join
        repeat (10) next_cycle();  // no response beyond the last line
        if (out_req) begin
            fail_run("an extra response appeared after the last test");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial begin
        wait (i_dut.i_props.failures != 0);
        fail_run("a handshake or latency assertion failed");
    end

    initial begin
        wait (loaded);
        #(PERIOD * (10 + CYCLES_PER_TEST * reqs.size()));
        fail_run("timeout: the tests did not complete in the allowed time");
    end

endmodule

/* testbench/exec_properties.sv */
`timescale 1ns/1ps

module exec_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 in_req,
    input logic                 in_ack,
    input exec_pkg::exec_req_t  in_data,
    input logic                 out_req,
    input logic                 out_ack,
    input exec_pkg::exec_resp_t out_data,
    input logic                 start,
    input logic                 done,
    input exec_pkg::exec_req_t  req
);

    int   failures = 0;  // watched by the testbench
    logic mul_start;

    assign mul_start = start && (req.op inside {exec_pkg::MULT, exec_pkg::MULTU,
        exec_pkg::MADD, exec_pkg::MADDU, exec_pkg::MSUB, exec_pkg::MSUBU});

    in_data_held: assert property (@(posedge clk) disable iff (reset)
        in_req && !in_ack |=> $stable(in_data))
        else begin failures++; $error("in_data changed while waiting for in_ack"); end

    out_data_held: assert property (@(posedge clk) disable iff (reset)
        out_req && !out_ack |=> $stable(out_data))
        else begin failures++; $error("out_data changed while waiting for out_ack"); end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else begin failures++; $error("in_ack rose without in_req"); end

    mul_latency: assert property (@(posedge clk) disable iff (reset)
        mul_start |-> ##(exec_pkg::MUL_LATENCY) done)
        else begin failures++; $error("multiply done did not follow start in time"); end

endmodule

bind exec_top exec_properties i_props (
    .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack), .in_data(in_data),
    .out_req(out_req), .out_ack(out_ack), .out_data(out_data),
    .start(start), .done(done), .req(req)
);

/* design/exec_top.sv */
`timescale 1ns/1ps

module exec_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    input  exec_pkg::exec_req_t  in_data,
    output logic                 in_ack,
    output logic                 out_req,
    input  logic                 out_ack,
    output exec_pkg::exec_resp_t out_data
);

    exec_pkg::exec_req_t  req;
    exec_pkg::exec_resp_t resp;
    exec_pkg::exec_resp_t head;
    exec_pkg::md_word_u   div_word;
    logic                 start;
    logic                 busy;
    logic                 full;
    logic                 done;
    logic                 empty;
    logic                 pop;
    logic                 div_start;
    logic                 div_signed;
    logic                 div_done;
    logic [31:0]          div_dividend;
    logic [31:0]          div_divisor;

    issue_port u_issue (
        .clk(clk), .reset(reset), .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .busy(busy), .full(full), .start(start), .req(req)
    );

    alu_core u_core (
        .clk(clk), .reset(reset), .start(start), .req(req),
        .busy(busy), .done(done), .resp(resp),
        .div_start(div_start), .div_signed(div_signed),
        .div_dividend(div_dividend), .div_divisor(div_divisor),
        .div_done(div_done), .div_word(div_word)
    );

    md_divider u_div (
        .clk(clk), .reset(reset), .div_start(div_start), .div_signed(div_signed),
        .div_dividend(div_dividend), .div_divisor(div_divisor),
        .div_done(div_done), .div_word(div_word)
    );

    result_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .reset(reset), .reserve(start), .push(done), .push_data(resp),
        .pop(pop), .head(head), .empty(empty), .full(full)
    );

    result_port u_out (
        .clk(clk), .reset(reset), .empty(empty), .head(head), .pop(pop),
        .out_req(out_req), .out_ack(out_ack), .out_data(out_data)
    );

endmodule

/* design/result_port.sv */
`timescale 1ns/1ps

module result_port (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 empty,
    input  exec_pkg::exec_resp_t head,
    output logic                 pop,
    output logic                 out_req,
    input  logic                 out_ack,
    output exec_pkg::exec_resp_t out_data
);

    typedef enum logic [1:0] {IDLE, PRESENT, WAIT_LOW} state_e;
    state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            out_req <= 1'b0;
            pop     <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                IDLE: begin
                    if (!empty) begin
                        out_req <= 1'b1;
                        state   <= PRESENT;
                    end
                end
                PRESENT: begin
                    if (out_ack) begin
                        pop     <= 1'b1;  // head leaves the queue
                        out_req <= 1'b0;
                        state   <= WAIT_LOW;
                    end
                end
                WAIT_LOW: if (!out_ack) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && !empty) out_data <= head;
    end

endmodule

/* design/result_fifo.sv */
`timescale 1ns/1ps

module result_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reserve,
    input  logic                 push,
    input  exec_pkg::exec_resp_t push_data,
    input  logic                 pop,
    output exec_pkg::exec_resp_t head,
    output logic                 empty,
    output logic                 full
);

    localparam int AW = $clog2(DEPTH);

    exec_pkg::exec_resp_t mem [DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          stored;
    logic                 pending;  // slot held for the op in the core

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            stored  <= '0;
            pending <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) stored <= stored + 1'b1;
            else if (pop && !push) stored <= stored - 1'b1;
            if (reserve) pending <= 1'b1;
            else if (push) pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    // a push into an empty queue is visible at once
    assign head  = (stored == '0) ? push_data : mem[rd_ptr];
    assign empty = (stored == '0) && !push;
    assign full  = (int'(stored) + int'(pending)) >= DEPTH;

endmodule

/* design/md_divider.sv */
`timescale 1ns/1ps

module md_divider (
    input  logic               clk,
    input  logic               reset,
    input  logic               div_start,
    input  logic               div_signed,
    input  logic [31:0]        div_dividend,
    input  logic [31:0]        div_divisor,
    output logic               div_done,
    output exec_pkg::md_word_u div_word
);

    logic [31:0] rem;
    logic [31:0] quo;
    logic [31:0] dvsr;
    logic [5:0]  cnt;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] mag_n;
    logic [31:0] mag_d;
    logic [31:0] cur_rem;
    logic [31:0] cur_quo;
    logic [31:0] cur_d;
    logic [32:0] shifted;
    logic [32:0] trial;

    assign mag_n = (div_signed && div_dividend[31]) ? -div_dividend : div_dividend;
    assign mag_d = (div_signed && div_divisor[31]) ? -div_divisor : div_divisor;

    // first step works straight on the operands
    assign cur_rem = div_start ? 32'd0 : rem;
    assign cur_quo = div_start ? mag_n : quo;
    assign cur_d   = div_start ? mag_d : dvsr;
    assign shifted = {cur_rem, cur_quo[31]};
    assign trial   = shifted - {1'b0, cur_d};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                cnt <= 6'(exec_pkg::DIV_STEPS - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == 6'd1) div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start || cnt != '0) begin
            rem <= trial[32] ? shifted[31:0] : trial[31:0];  // restore on borrow
            quo <= {cur_quo[30:0], ~trial[32]};
        end
        if (div_start) begin
            dvsr  <= mag_d;
            neg_q <= div_signed && (div_dividend[31] ^ div_divisor[31])
                     && (div_divisor != 32'd0);  // x/0 keeps all ones
            neg_r <= div_signed && div_dividend[31];
        end
    end

    always_comb begin
        div_word.divres.rem = neg_r ? -rem : rem;
        div_word.divres.quo = neg_q ? -quo : quo;
    end

endmodule

/* design/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  exec_pkg::exec_req_t  req,
    output logic                 busy,
    output logic                 done,
    output exec_pkg::exec_resp_t resp,
    output logic                 div_start,
    output logic                 div_signed,
    output logic [31:0]          div_dividend,
    output logic [31:0]          div_divisor,
    input  logic                 div_done,
    input  exec_pkg::md_word_u   div_word
);

    localparam int CW = $clog2(exec_pkg::MUL_LATENCY + 1);

    exec_pkg::exec_op_e op;
    exec_pkg::exec_op_e mul_op;
    exec_pkg::md_word_u hilo;
    logic [31:0]        a;
    logic [31:0]        b;
    logic               sub_mode;
    logic [31:0]        adder_b;
    logic [31:0]        sum;
    logic               carry;
    logic               lt_s;
    logic               lt_u;
    logic [31:0]        count_src;
    logic [5:0]         lead;
    logic [31:0]        result;
    logic               overflow;
    logic               trap;
    logic               is_mul;
    logic               is_div;
    logic               mul_signed;
    logic [31:0]        mag_a;
    logic [31:0]        mag_b;
    logic               mul_neg;
    logic [63:0]        mag_prod;
    logic [63:0]        prod;
    logic [63:0]        acc;
    logic [CW-1:0]      mul_cnt;
    logic               div_wait;

    assign op = req.op;
    assign a  = req.src1;
    assign b  = req.src2;

    // one adder for add/sub, set-less-than and the trap compares
    assign sub_mode     = !(op inside {exec_pkg::ADD, exec_pkg::ADDU});
    assign adder_b      = sub_mode ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, adder_b} + 33'(sub_mode);
    assign lt_u         = ~carry;
    assign lt_s         = (a[31] & ~b[31]) | (~(a[31] ^ b[31]) & sum[31]);
    assign overflow     = (op inside {exec_pkg::ADD, exec_pkg::SUB})
                          && (a[31] == adder_b[31]) && (sum[31] != a[31]);

    assign count_src = (op == exec_pkg::CLO) ? ~a : a;  // clo counts zeros of ~a

    always_comb begin
        lead = 6'd32;
        for (int i = 31; i >= 0; i--) begin
            if (count_src[i] && lead == 6'd32) lead = 6'(31 - i);
        end
    end

    always_comb begin
        case (op)
            exec_pkg::TEQ:  trap = (a == b);
            exec_pkg::TNE:  trap = (a != b);
            exec_pkg::TGE:  trap = !lt_s;
            exec_pkg::TGEU: trap = !lt_u;
            exec_pkg::TLT:  trap = lt_s;
            exec_pkg::TLTU: trap = lt_u;
            default:        trap = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            exec_pkg::ADD, exec_pkg::SUB,
            exec_pkg::ADDU, exec_pkg::SUBU: result = sum;
            exec_pkg::SLT:  result = {31'b0, lt_s};
            exec_pkg::SLTU: result = {31'b0, lt_u};
            exec_pkg::AND:  result = a & b;
            exec_pkg::OR:   result = a | b;
            exec_pkg::NOR:  result = ~(a | b);
            exec_pkg::XOR:  result = a ^ b;
            exec_pkg::LUI:  result = {b[15:0], 16'h0000};
            exec_pkg::SLL:  result = b << a[4:0];
            exec_pkg::SRL:  result = b >> a[4:0];
            exec_pkg::SRA:  result = $signed(b) >>> a[4:0];
            exec_pkg::CLO, exec_pkg::CLZ: result = 32'(lead);
            exec_pkg::MOVN: result = (a != 32'd0) ? b : 32'd0;
            exec_pkg::MOVZ: result = (a == 32'd0) ? b : 32'd0;
            exec_pkg::MFHI: result = hilo.prod[63:32];
            exec_pkg::MFLO: result = hilo.prod[31:0];
            default:        result = 32'd0;  // HI/LO-only ops
        endcase
    end

    assign is_mul     = op inside {exec_pkg::MULT, exec_pkg::MULTU, exec_pkg::MADD,
                                   exec_pkg::MADDU, exec_pkg::MSUB, exec_pkg::MSUBU};
    assign is_div     = op inside {exec_pkg::DIV, exec_pkg::DIVU};
    assign mul_signed = op inside {exec_pkg::MULT, exec_pkg::MADD, exec_pkg::MSUB};

    assign div_start    = start && is_div;
    assign div_signed   = (op == exec_pkg::DIV);
    assign div_dividend = a;
    assign div_divisor  = b;

    assign prod = mul_neg ? -mag_prod : mag_prod;  // sign correction

    always_comb begin
        case (mul_op)
            exec_pkg::MADD, exec_pkg::MADDU: acc = hilo.prod + prod;
            exec_pkg::MSUB, exec_pkg::MSUBU: acc = hilo.prod - prod;
            default:                         acc = prod;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            resp.result   <= result;
            resp.overflow <= overflow;
            resp.trap     <= trap;
            mul_op        <= op;
            mag_a         <= (mul_signed && a[31]) ? -a : a;
            mag_b         <= (mul_signed && b[31]) ? -b : b;
            mul_neg       <= mul_signed && (a[31] ^ b[31]);
        end
        mag_prod <= mag_a * mag_b;  // settles one cycle after start
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            mul_cnt  <= '0;
            div_wait <= 1'b0;
            hilo     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                if (is_mul) begin
                    busy    <= 1'b1;
                    mul_cnt <= CW'(exec_pkg::MUL_LATENCY - 1);
                end else if (is_div) begin
                    busy     <= 1'b1;
                    div_wait <= 1'b1;
                end else begin
                    done <= 1'b1;
                    if (op == exec_pkg::MTHI) hilo.prod[63:32] <= a;
                    if (op == exec_pkg::MTLO) hilo.prod[31:0] <= a;
                end
            end
            if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == CW'(1)) begin
                    done      <= 1'b1;
                    busy      <= 1'b0;
                    hilo.prod <= acc;
                end
            end
            if (div_wait && div_done) begin
                done     <= 1'b1;
                busy     <= 1'b0;
                div_wait <= 1'b0;
                hilo     <= div_word;  // remainder to HI, quotient to LO
            end
        end
    end

endmodule

/* design/issue_port.sv */
`timescale 1ns/1ps

module issue_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    input  exec_pkg::exec_req_t in_data,
    output logic                in_ack,
    input  logic                busy,
    input  logic                full,
    output logic                start,
    output exec_pkg::exec_req_t req
);

    typedef enum logic [1:0] {IDLE, HOLD, ACK} state_e;
    state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            in_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: if (in_req) state <= HOLD;  // in_ack is low here
                HOLD: begin
                    if (!busy && !full) begin  // core free and a slot left
                        start  <= 1'b1;
                        in_ack <= 1'b1;
                        state  <= ACK;
                    end
                end
                ACK: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_req) req <= in_data;
    end

endmodule

/* design/exec_pkg.sv */
package exec_pkg;

    localparam int MUL_LATENCY = 3;  // start to done, mult family
    localparam int DIV_STEPS   = 32;

    typedef enum logic [5:0] {
        ADD, SUB, ADDU, SUBU,
        SLT, SLTU,
        AND, OR, NOR, XOR,
        LUI,
        SLL, SRL, SRA,
        CLO, CLZ,
        MOVN, MOVZ,
        TEQ, TNE, TGE, TGEU, TLT, TLTU,
        MULT, MULTU, DIV, DIVU,
        MADD, MADDU, MSUB, MSUBU,
        MFHI, MFLO, MTHI, MTLO
    } exec_op_e;

    typedef struct packed {
        exec_op_e    op;
        logic [31:0] src1;
        logic [31:0] src2;
    } exec_req_t;

    typedef struct packed {
        logic [31:0] result;
        logic        overflow;
        logic        trap;
    } exec_resp_t;

    typedef struct packed {
        logic [31:0] rem;  // lands in HI
        logic [31:0] quo;  // lands in LO
    } md_divres_t;

    typedef union packed {
        logic [63:0] prod;  // {HI, LO}
        md_divres_t  divres;
    } md_word_u;

endpackage
